/* src/bev_pkg.sv */
`default_nettype none

package bev_pkg;

    //========================================
    // Sizes and limits
    //========================================

    localparam int ING_W    = 12;
    localparam int ING_MAX  = 4095;
    localparam int NUM_ING  = 4;
    localparam int CNT_W    = $clog2(NUM_ING);
    localparam int BARREL_W = 8;

    // DRAM byte addressing, one 64-bit word per barrel
    localparam int ADDR_W         = 17;
    localparam int REC_BYTES_LOG2 = 3;
    localparam logic [ADDR_W-BARREL_W-REC_BYTES_LOG2-1:0] DRAM_BASE = 6'b100000;

    //========================================
    // Command and result codes
    //========================================

    typedef enum logic [1:0] {
        Make_drink       = 2'd0,
        Supply           = 2'd1,
        Check_Valid_Date = 2'd2
    } action_e;

    typedef enum logic [1:0] {
        No_Err = 2'd0,
        No_Exp = 2'd1,
        No_Ing = 2'd2,
        Ing_OF = 2'd3
    } err_e;

    typedef struct packed {
        logic [3:0] month;
        logic [4:0] day;
    } date_t;

    // Element 0 is black tea, then green tea, milk, pineapple juice
    typedef logic [0:NUM_ING-1][ING_W-1:0] ing_vec_t;

    typedef struct packed {
        action_e               action;
        date_t                 date;
        logic [BARREL_W-1:0]   barrel;
        ing_vec_t              amount;
    } cmd_t;

    // Layout of the 64-bit DRAM word
    typedef struct packed {
        logic [ING_W-1:0] black_tea;
        logic [ING_W-1:0] green_tea;
        logic [3:0]       pad_month;
        logic [3:0]       month;
        logic [ING_W-1:0] milk;
        logic [ING_W-1:0] pineapple_juice;
        logic [2:0]       pad_day;
        logic [4:0]       day;
    } bev_rec_t;

    //========================================
    // Helpers
    //========================================

    function automatic logic [ADDR_W-1:0] rec_addr(input logic [BARREL_W-1:0] idx);
        return {DRAM_BASE, idx, {REC_BYTES_LOG2{1'b0}}};
    endfunction

    function automatic ing_vec_t rec_ing(input bev_rec_t rec);
        return {rec.black_tea, rec.green_tea, rec.milk, rec.pineapple_juice};
    endfunction

    // Rebuild a record, pad bits come back as zero
    function automatic bev_rec_t rec_pack(input ing_vec_t ing, input date_t d);
        bev_rec_t rec;
        rec                 = '0;
        rec.black_tea       = ing[0];
        rec.green_tea       = ing[1];
        rec.milk            = ing[2];
        rec.pineapple_juice = ing[3];
        rec.month           = d.month;
        rec.day             = d.day;
        return rec;
    endfunction

endpackage

`default_nettype wire

/* src/cmd_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module cmd_decode
    import bev_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmd_valid,
    input  cmd_t              cmd,
    input  logic              ar_ready,
    input  logic              r_valid,
    input  bev_rec_t          r_data,
    input  logic              out_valid,
    output logic              ar_valid,
    output logic              r_ready,
    output logic [ADDR_W-1:0] ar_addr,
    output logic              fetch_valid,
    output cmd_t              fetch_cmd,
    output bev_rec_t          fetch_rec
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_BUSY
    } state_e;

    state_e   state, state_nxt;
    logic     ar_valid_nxt;
    logic     r_ready_nxt;
    logic     fetch_nxt;

    cmd_t     cmd_q;
    bev_rec_t rec_q;

    //========================================
    // FSM
    //========================================

    always_comb begin
        state_nxt    = state;
        ar_valid_nxt = 1'b0;
        r_ready_nxt  = 1'b0;
        fetch_nxt    = 1'b0;
        case (state)
            S_IDLE: begin
                if (cmd_valid) begin
                    state_nxt    = S_ADDR;
                    ar_valid_nxt = 1'b1;
                end
            end
            S_ADDR: begin
                if (ar_valid && ar_ready) begin
                    state_nxt   = S_DATA;
                    r_ready_nxt = 1'b1;
                end else begin
                    ar_valid_nxt = 1'b1;
                end
            end
            S_DATA: begin
                if (r_valid && r_ready) begin
                    state_nxt = S_BUSY;
                    fetch_nxt = 1'b1;
                end else begin
                    r_ready_nxt = 1'b1;
                end
            end
            // Hold the command until the response has gone out
            S_BUSY: begin
                if (out_valid) begin
                    state_nxt = S_IDLE;
                end
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            ar_valid    <= 1'b0;
            r_ready     <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            state       <= state_nxt;
            ar_valid    <= ar_valid_nxt;
            r_ready     <= r_ready_nxt;
            fetch_valid <= fetch_nxt;
        end
    end

    //========================================
    // Command and record capture
    //========================================

    always_ff @(posedge clk) begin
        if (state == S_IDLE && cmd_valid) begin
            cmd_q <= cmd;
        end
        if (r_valid && r_ready) begin
            rec_q <= r_data;
        end
    end

    assign ar_addr   = rec_addr(cmd_q.barrel);
    assign fetch_cmd = cmd_q;
    assign fetch_rec = rec_q;

endmodule

`default_nettype wire

/* src/bev_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module bev_execute
    import bev_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fetch_valid,
    input  cmd_t     fetch_cmd,
    input  bev_rec_t fetch_rec,
    output logic     exec_done,
    output bev_rec_t exec_rec,
    output err_e     exec_err,
    output logic     exec_write
);

    logic             running;
    logic [CNT_W-1:0] cnt;
    logic             step;
    logic             last_step;

    ing_vec_t         ing_q, amt_q;
    ing_vec_t         src_ing, src_amt;
    ing_vec_t         ing_nxt, amt_nxt;

    logic             is_make, is_supply;
    logic             do_sub;
    logic [ING_W:0]   add_a, add_b, add_z;
    logic [ING_W-1:0] step_res;
    logic             borrow, clamp;

    logic             expired;
    logic             exp_q, short_q, of_q;
    date_t            new_date;

    assign is_make   = (fetch_cmd.action == Make_drink);
    assign is_supply = (fetch_cmd.action == Supply);

    // First ingredient is taken straight from the fetched record
    assign step      = fetch_valid || running;
    assign last_step = running && (cnt == CNT_W'(NUM_ING - 1));

    //========================================
    // Shared 13-bit adder
    //========================================

    assign src_ing = fetch_valid ? rec_ing(fetch_rec) : ing_q;
    assign src_amt = fetch_valid ? fetch_cmd.amount : amt_q;

    assign do_sub = is_make;
    assign add_a  = {1'b0, src_ing[0]};
    assign add_b  = do_sub ? ~{1'b0, src_amt[0]} : {1'b0, src_amt[0]};
    assign add_z  = add_a + add_b + {{ING_W{1'b0}}, do_sub};

    // Top bit is the borrow on subtract and the carry on add
    assign borrow   = is_make && add_z[ING_W];
    assign clamp    = is_supply && add_z[ING_W];
    assign step_res = clamp ? ING_W'(ING_MAX) : add_z[ING_W-1:0];

    // Rotate so the updated value goes to the back of the queue
    always_comb begin
        for (int i = 0; i < NUM_ING - 1; i++) begin
            ing_nxt[i] = src_ing[i+1];
            amt_nxt[i] = src_amt[i+1];
        end
        ing_nxt[NUM_ING-1] = step_res;
        amt_nxt[NUM_ING-1] = src_amt[0];
    end

    always_ff @(posedge clk) begin
        if (step) begin
            ing_q <= ing_nxt;
            amt_q <= amt_nxt;
        end
    end

    //========================================
    // Sequencing and flags
    //========================================

    assign expired = (fetch_cmd.date.month > fetch_rec.month) ||
                     ((fetch_cmd.date.month == fetch_rec.month) &&
                      (fetch_cmd.date.day > fetch_rec.day));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running   <= 1'b0;
            cnt       <= '0;
            exec_done <= 1'b0;
            exp_q     <= 1'b0;
            short_q   <= 1'b0;
            of_q      <= 1'b0;
        end else begin
            exec_done <= last_step;
            if (fetch_valid) begin
                running <= 1'b1;
                cnt     <= CNT_W'(1);
                exp_q   <= expired;
                short_q <= borrow;
                of_q    <= clamp;
            end else if (running) begin
                cnt     <= cnt + 1'b1;
                short_q <= short_q | borrow;
                of_q    <= of_q | clamp;
                if (last_step) begin
                    running <= 1'b0;
                end
            end
        end
    end

    //========================================
    // Error and write decision
    //========================================

    always_comb begin
        case (fetch_cmd.action)
            Make_drink: begin
                if (exp_q) begin
                    exec_err = No_Exp;
                end else if (short_q) begin
                    exec_err = No_Ing;
                end else begin
                    exec_err = No_Err;
                end
            end
            Supply:  exec_err = of_q ? Ing_OF : No_Err;
            default: exec_err = exp_q ? No_Exp : No_Err;
        endcase
    end

    assign exec_write = is_supply || (is_make && exec_err == No_Err);

    // Supply stamps today, a drink keeps the stored date
    assign new_date = is_supply ? fetch_cmd.date : date_t'({fetch_rec.month, fetch_rec.day});
    assign exec_rec = exec_write ? rec_pack(ing_q, new_date) : fetch_rec;

endmodule

`default_nettype wire

/* src/result_writeback.sv */
`timescale 1ns/10ps
`default_nettype none

module result_writeback
    import bev_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              exec_done,
    input  bev_rec_t          exec_rec,
    input  err_e              exec_err,
    input  logic              exec_write,
    input  cmd_t              fetch_cmd,
    input  logic              aw_ready,
    input  logic              w_ready,
    input  logic              b_valid,
    output logic              aw_valid,
    output logic              w_valid,
    output logic              b_ready,
    output logic [ADDR_W-1:0] aw_addr,
    output bev_rec_t          w_data,
    output logic              out_valid,
    output err_e              err
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_RESP
    } state_e;

    state_e   state;
    bev_rec_t rec_q;
    err_e     err_q;

    //========================================
    // Write channel FSM
    //========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            aw_valid  <= 1'b0;
            w_valid   <= 1'b0;
            b_ready   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (exec_done) begin
                        if (exec_write) begin
                            state    <= S_ADDR;
                            aw_valid <= 1'b1;
                        end else begin
                            // Nothing to store, answer right away
                            out_valid <= 1'b1;
                        end
                    end
                end
                S_ADDR: begin
                    if (aw_valid && aw_ready) begin
                        state    <= S_DATA;
                        aw_valid <= 1'b0;
                        w_valid  <= 1'b1;
                        b_ready  <= 1'b1;
                    end
                end
                S_DATA: begin
                    if (w_valid && w_ready) begin
                        state   <= S_RESP;
                        w_valid <= 1'b0;
                    end
                end
                S_RESP: begin
                    if (b_valid && b_ready) begin
                        state     <= S_IDLE;
                        b_ready   <= 1'b0;
                        out_valid <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    //========================================
    // Result payload
    //========================================

    always_ff @(posedge clk) begin
        if (state == S_IDLE && exec_done) begin
            rec_q <= exec_rec;
            err_q <= exec_err;
        end
    end

    // Command stays registered upstream until out_valid
    assign aw_addr = rec_addr(fetch_cmd.barrel);
    assign w_data  = rec_q;
    assign err     = err_q;

endmodule

`default_nettype wire

/* src/bev_bridge_top.sv */
`timescale 1ns/10ps
`default_nettype none

module bev_bridge_top
    import bev_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    // Command in
    input  logic              cmd_valid,
    input  cmd_t              cmd,
    // DRAM read address and data
    output logic              ar_valid,
    output logic [ADDR_W-1:0] ar_addr,
    input  logic              ar_ready,
    input  logic              r_valid,
    input  bev_rec_t          r_data,
    output logic              r_ready,
    // DRAM write address, data and response
    output logic              aw_valid,
    output logic [ADDR_W-1:0] aw_addr,
    input  logic              aw_ready,
    output logic              w_valid,
    output bev_rec_t          w_data,
    input  logic              w_ready,
    input  logic              b_valid,
    output logic              b_ready,
    // Result
    output logic              out_valid,
    output err_e              err
);

    //========================================
    // Stage links
    //========================================

    logic     fetch_valid;
    cmd_t     fetch_cmd;
    bev_rec_t fetch_rec;

    logic     exec_done;
    bev_rec_t exec_rec;
    err_e     exec_err;
    logic     exec_write;

    cmd_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .ar_ready   (ar_ready),
        .r_valid    (r_valid),
        .r_data     (r_data),
        .out_valid  (out_valid),
        .ar_valid   (ar_valid),
        .r_ready    (r_ready),
        .ar_addr    (ar_addr),
        .fetch_valid(fetch_valid),
        .fetch_cmd  (fetch_cmd),
        .fetch_rec  (fetch_rec)
    );

    bev_execute u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_valid(fetch_valid),
        .fetch_cmd  (fetch_cmd),
        .fetch_rec  (fetch_rec),
        .exec_done  (exec_done),
        .exec_rec   (exec_rec),
        .exec_err   (exec_err),
        .exec_write (exec_write)
    );

    result_writeback u_writeback (
        .clk       (clk),
        .rst_n     (rst_n),
        .exec_done (exec_done),
        .exec_rec  (exec_rec),
        .exec_err  (exec_err),
        .exec_write(exec_write),
        .fetch_cmd (fetch_cmd),
        .aw_ready  (aw_ready),
        .w_ready   (w_ready),
        .b_valid   (b_valid),
        .aw_valid  (aw_valid),
        .w_valid   (w_valid),
        .b_ready   (b_ready),
        .aw_addr   (aw_addr),
        .w_data    (w_data),
        .out_valid (out_valid),
        .err       (err)
    );

endmodule

`default_nettype wire

/* verif/bev_model.svh */
`ifndef BEV_MODEL_SVH
`define BEV_MODEL_SVH

// DRAM image served on the bus and the image the model expects
bev_rec_t dram_mem [256];
bev_rec_t model_mem [256];

// True when today is past the stored date
function automatic logic date_later(input date_t today, input logic [3:0] month,
                                    input logic [4:0] day);
    return (today.month > month) || ((today.month == month) && (today.day > day));
endfunction

// Expected error, new record and write decision for one command
task automatic predict(input cmd_t c, input bev_rec_t rec, output err_e e,
                       output bev_rec_t nr, output logic wr);
    logic [ING_W-1:0] stock [NUM_ING];
    logic [ING_W:0]   sum;
    logic             expired;
    logic             short;
    logic             over;
    stock[0] = rec.black_tea;
    stock[1] = rec.green_tea;
    stock[2] = rec.milk;
    stock[3] = rec.pineapple_juice;
    expired  = date_later(c.date, rec.month, rec.day);
    short    = 1'b0;
    over     = 1'b0;
    for (int i = 0; i < NUM_ING; i++) begin
        if (c.action == Make_drink) begin
            if (c.amount[i] > stock[i]) short = 1'b1;
            stock[i] = stock[i] - c.amount[i];
        end else if (c.action == Supply) begin
            sum = {1'b0, stock[i]} + {1'b0, c.amount[i]};
            if (sum > ING_MAX) begin
                over     = 1'b1;
                stock[i] = ING_W'(ING_MAX);
            end else begin
                stock[i] = sum[ING_W-1:0];
            end
        end
    end
    case (c.action)
        Make_drink: e = expired ? No_Exp : (short ? No_Ing : No_Err);
        Supply:     e = over ? Ing_OF : No_Err;
        default:    e = expired ? No_Exp : No_Err;
    endcase
    wr = (c.action == Supply) || ((c.action == Make_drink) && (e == No_Err));
    nr = rec;
    if (wr) begin
        nr                 = '0;
        nr.black_tea       = stock[0];
        nr.green_tea       = stock[1];
        nr.milk            = stock[2];
        nr.pineapple_juice = stock[3];
        nr.month           = (c.action == Supply) ? c.date.month : rec.month;
        nr.day             = (c.action == Supply) ? c.date.day : rec.day;
    end
endtask

`endif

/* verif/bev_bridge_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module bev_bridge_tb
    import bev_pkg::*;
;

    localparam int CLK_PERIOD = 20;
    localparam int WAIT_LIMIT = 200;
    localparam int NUM_CMDS   = 300;

    logic              clk;
    logic              rst_n;
    logic              cmd_valid;
    cmd_t              cmd;
    logic              ar_valid, ar_ready;
    logic [ADDR_W-1:0] ar_addr;
    logic              r_valid, r_ready;
    bev_rec_t          r_data;
    logic              aw_valid, aw_ready;
    logic [ADDR_W-1:0] aw_addr;
    logic              w_valid, w_ready;
    bev_rec_t          w_data;
    logic              b_valid, b_ready;
    logic              out_valid;
    err_e              err;

    integer            seed = 32'h2aa9_4a6b;
    int                pulse_count = 0;
    logic              ar_hold, r_hold, aw_hold, w_hold, b_hold;

    `include "bev_model.svh"

    bev_bridge_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //========================================
    // Reporting and helpers
    //========================================

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] got);
        $display("[ERROR] %s expected %h got %h", name, exp, got);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // One clock step inside a bounded wait
    task automatic step_wait(inout int t, input string what);
        @(posedge clk);
        t++;
        if (t > WAIT_LIMIT) report_failure({"Timed out waiting for ", what});
    endtask

    task automatic random_delay();
        repeat (rand_below(6)) @(posedge clk);
    endtask

    //========================================
    // Handshake monitor
    //========================================

    // Sampled values at the edge, so a valid or ready seen waiting must still be up
    always @(posedge clk) begin
        if (!rst_n) begin
            ar_hold = 1'b0;
            r_hold  = 1'b0;
            aw_hold = 1'b0;
            w_hold  = 1'b0;
            b_hold  = 1'b0;
        end else begin
            if (out_valid) pulse_count++;
            assert (!(ar_hold && !ar_valid)) else report_failure("ar_valid dropped early");
            assert (!(r_hold && !r_ready)) else report_failure("r_ready dropped early");
            assert (!(aw_hold && !aw_valid)) else report_failure("aw_valid dropped early");
            assert (!(w_hold && !w_valid)) else report_failure("w_valid dropped early");
            assert (!(b_hold && !b_ready)) else report_failure("b_ready dropped early");
            ar_hold = ar_valid && !ar_ready;
            r_hold  = r_ready && !r_valid;
            aw_hold = aw_valid && !aw_ready;
            w_hold  = w_valid && !w_ready;
            b_hold  = b_ready && !b_valid;
        end
    end

    //========================================
    // DRAM responder for one command
    //========================================

    task automatic serve_read(input logic [7:0] idx);
        int t;
        t = 0;
        while (!ar_valid) step_wait(t, "ar_valid");
        random_delay();
        ar_ready <= 1'b1;
        t = 0;
        do step_wait(t, "ar handshake"); while (!(ar_valid && ar_ready));
        assert (ar_addr == {DRAM_BASE, idx, 3'b000})
            else report_mismatch("ar_addr", {DRAM_BASE, idx, 3'b000}, ar_addr);
        ar_ready <= 1'b0;
        random_delay();
        r_valid <= 1'b1;
        r_data  <= dram_mem[idx];
        t = 0;
        do step_wait(t, "r handshake"); while (!(r_valid && r_ready));
        r_valid <= 1'b0;
    endtask

    task automatic serve_write(input logic [7:0] idx, input bev_rec_t exp_rec);
        int t;
        random_delay();
        aw_ready <= 1'b1;
        t = 0;
        do step_wait(t, "aw handshake"); while (!(aw_valid && aw_ready));
        assert (aw_addr == {DRAM_BASE, idx, 3'b000})
            else report_mismatch("aw_addr", {DRAM_BASE, idx, 3'b000}, aw_addr);
        aw_ready <= 1'b0;
        random_delay();
        w_ready <= 1'b1;
        t = 0;
        do step_wait(t, "w handshake"); while (!(w_valid && w_ready));
        assert (w_data == exp_rec) else report_mismatch("w_data", exp_rec, w_data);
        dram_mem[idx] = w_data;
        w_ready <= 1'b0;
        random_delay();
        b_valid <= 1'b1;
        t = 0;
        do step_wait(t, "b handshake"); while (!(b_valid && b_ready));
        b_valid <= 1'b0;
    endtask

    //========================================
    // Stimulus
    //========================================

    function automatic date_t random_date();
        date_t d;
        d.month = 4'(1 + rand_below(12));
        d.day   = 5'(1 + rand_below(28));
        return d;
    endfunction

    task automatic fill_memory();
        bev_rec_t rec;
        date_t    d;
        for (int i = 0; i < 256; i++) begin
            d                   = random_date();
            rec                 = '0;
            rec.black_tea       = 12'(rand_below(4096));
            rec.green_tea       = 12'(rand_below(4096));
            rec.milk            = 12'(rand_below(4096));
            rec.pineapple_juice = 12'(rand_below(4096));
            rec.month           = d.month;
            rec.day             = d.day;
            dram_mem[i]         = rec;
            model_mem[i]        = rec;
        end
    endtask

    task automatic run_command();
        cmd_t     c;
        err_e     exp_err;
        bev_rec_t exp_rec;
        logic     exp_wr;
        int       start;
        int       t;
        c.action = action_e'(rand_below(3));
        c.date   = random_date();
        c.barrel = 8'(rand_below(256));
        // Small amounts half the time so drinks and supplies both succeed often
        for (int i = 0; i < NUM_ING; i++) begin
            c.amount[i] = 12'(rand_below(2) == 0 ? rand_below(512) : rand_below(4096));
        end
        predict(c, model_mem[c.barrel], exp_err, exp_rec, exp_wr);
        start = pulse_count;
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(posedge clk);
        cmd_valid <= 1'b0;
        serve_read(c.barrel);
        t = 0;
        while (!out_valid && !aw_valid) step_wait(t, "out_valid or aw_valid");
        if (aw_valid) begin
            assert (exp_wr) else report_failure("Write-back started for a command without one");
            serve_write(c.barrel, exp_rec);
            t = 0;
            while (!out_valid) step_wait(t, "out_valid");
        end else begin
            assert (!exp_wr) else report_failure("Response came without the expected write-back");
        end
        assert (err == exp_err) else report_mismatch("err", 64'(exp_err), 64'(err));
        if (exp_wr) model_mem[c.barrel] = exp_rec;
        repeat (2) @(posedge clk);
        assert (pulse_count == start + 1)
            else report_mismatch("out_valid pulses", 64'(start + 1), 64'(pulse_count));
    endtask

    initial begin
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        ar_ready  = 1'b0;
        r_valid   = 1'b0;
        r_data    = '0;
        aw_ready  = 1'b0;
        w_ready   = 1'b0;
        b_valid   = 1'b0;
        fill_memory();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        for (int n = 0; n < NUM_CMDS; n++) begin
            run_command();
        end
        // Final DRAM image against the model
        for (int i = 0; i < 256; i++) begin
            assert (dram_mem[i] == model_mem[i])
                else report_mismatch("dram_mem", model_mem[i], dram_mem[i]);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verif
src/bev_pkg.sv
src/cmd_decode.sv
src/bev_execute.sv
src/result_writeback.sv
src/bev_bridge_top.sv
verif/bev_bridge_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f \
    --top-module bev_bridge_tb -o bev_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/bev_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi

exit 0
